// File: run_sim.sh
#!/usr/bin/env bash
# Builds the metering testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

log_file=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps -f sim.f \
    --top-module camera_metering_tb -Mdir obj_dir -o camera_metering_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/camera_metering_sim > "$log_file" 2>&1
run_status=$?
cat "$log_file"
if [ $run_status -ne 0 ]; then
    echo "Simulation exited with status $run_status"
    exit 1
fi

if grep -q "Simulation finished: PASS" "$log_file"; then
    exit 0
fi
echo "Pass message not found in $log_file"
exit 1

// File: sim.f
source/camera_metering_pkg.sv
source/metering_config_regs.sv
source/window_brightness.sv
source/exposure_stepper.sv
source/camera_metering_top.sv
verif/camera_metering_tb.sv

// File: source/camera_metering_pkg.sv
/*
 * Shared widths, configuration register addresses and register reset values
 * for the auto-exposure metering path.
 */
`default_nettype none

package camera_metering_pkg;

    // Data path widths.
    localparam int unsigned PIXEL_WIDTH       = 10;
    localparam int unsigned AVERAGE_WIDTH     = 8;
    localparam int unsigned COORD_WIDTH       = 12;
    localparam int unsigned CFG_ADDRESS_WIDTH = 4;
    localparam int unsigned CFG_DATA_WIDTH    = 16;
    localparam int unsigned EXPOSURE_WIDTH    = 16;

    // Register map.
    localparam logic [CFG_ADDRESS_WIDTH-1:0] REG_X_WINDOW_START    = 4'd0;
    localparam logic [CFG_ADDRESS_WIDTH-1:0] REG_Y_WINDOW_START    = 4'd1;
    localparam logic [CFG_ADDRESS_WIDTH-1:0] REG_BRIGHTNESS_TARGET = 4'd2;
    localparam logic [CFG_ADDRESS_WIDTH-1:0] REG_DEADBAND          = 4'd3;
    localparam logic [CFG_ADDRESS_WIDTH-1:0] REG_EXPOSURE_STEP     = 4'd4;

    // Window origin after reset.
    localparam logic [COORD_WIDTH-1:0] RESET_X_WINDOW_START = 12'd82;
    localparam logic [COORD_WIDTH-1:0] RESET_Y_WINDOW_START = 12'd82;

    // Mid-scale brightness target with a modest deadband.
    localparam logic [AVERAGE_WIDTH-1:0] RESET_BRIGHTNESS_TARGET = 8'd128;
    localparam logic [AVERAGE_WIDTH-1:0] RESET_DEADBAND          = 8'd8;

    localparam logic [EXPOSURE_WIDTH-1:0] RESET_EXPOSURE_STEP = 16'd16;

endpackage

`default_nettype wire

// File: source/camera_metering_top.sv
/*
 * Auto-exposure metering top level: register block, window statistics and
 * exposure stepper in the pixel clock domain.
 */
`timescale 1ns/1ps
`default_nettype none

module camera_metering_top #(
    parameter int unsigned WINDOW_SIZE_LOG2 = 4,
    parameter int unsigned EXPOSURE_MIN     = 16,
    parameter int unsigned EXPOSURE_MAX     = 4000,
    parameter int unsigned EXPOSURE_INITIAL = 1000
) (
    input  wire                                              pixel_clock_in,
    input  wire                                              arst_n,

    // Pixel stream.
    input  wire  [camera_metering_pkg::PIXEL_WIDTH-1:0]       pixel_red,
    input  wire  [camera_metering_pkg::PIXEL_WIDTH-1:0]       pixel_green,
    input  wire  [camera_metering_pkg::PIXEL_WIDTH-1:0]       pixel_blue,
    input  wire                                              line_valid,
    input  wire                                              frame_valid,

    // Configuration port.
    input  wire                                              cfg_write,
    input  wire  [camera_metering_pkg::CFG_ADDRESS_WIDTH-1:0] cfg_address,
    input  wire  [camera_metering_pkg::CFG_DATA_WIDTH-1:0]    cfg_write_data,
    output wire  [camera_metering_pkg::CFG_DATA_WIDTH-1:0]    cfg_read_data,

    // Statistics and exposure results.
    output wire  [camera_metering_pkg::AVERAGE_WIDTH-1:0]     red_average,
    output wire  [camera_metering_pkg::AVERAGE_WIDTH-1:0]     green_average,
    output wire  [camera_metering_pkg::AVERAGE_WIDTH-1:0]     blue_average,
    output wire                                              stats_valid,
    output wire  [camera_metering_pkg::EXPOSURE_WIDTH-1:0]    exposure_value,
    output wire                                              exposure_update
);

    import camera_metering_pkg::*;

    wire [COORD_WIDTH-1:0]    x_window_start;
    wire [COORD_WIDTH-1:0]    y_window_start;
    wire [AVERAGE_WIDTH-1:0]  brightness_target;
    wire [AVERAGE_WIDTH-1:0]  deadband;
    wire [EXPOSURE_WIDTH-1:0] exposure_step;

    metering_config_regs u_config_regs (
        .pixel_clock_in    (pixel_clock_in),
        .arst_n            (arst_n),
        .cfg_write         (cfg_write),
        .cfg_address       (cfg_address),
        .cfg_write_data    (cfg_write_data),
        .cfg_read_data     (cfg_read_data),
        .x_window_start    (x_window_start),
        .y_window_start    (y_window_start),
        .brightness_target (brightness_target),
        .deadband          (deadband),
        .exposure_step     (exposure_step)
    );

    window_brightness #(
        .WINDOW_SIZE_LOG2 (WINDOW_SIZE_LOG2)
    ) u_window_brightness (
        .pixel_clock_in (pixel_clock_in),
        .arst_n         (arst_n),
        .pixel_red      (pixel_red),
        .pixel_green    (pixel_green),
        .pixel_blue     (pixel_blue),
        .line_valid     (line_valid),
        .frame_valid    (frame_valid),
        .x_window_start (x_window_start),
        .y_window_start (y_window_start),
        .red_average    (red_average),
        .green_average  (green_average),
        .blue_average   (blue_average),
        .stats_valid    (stats_valid)
    );

    // Steps once per frame, one cycle after the statistics land.
    exposure_stepper #(
        .EXPOSURE_MIN     (EXPOSURE_MIN),
        .EXPOSURE_MAX     (EXPOSURE_MAX),
        .EXPOSURE_INITIAL (EXPOSURE_INITIAL)
    ) u_exposure_stepper (
        .pixel_clock_in    (pixel_clock_in),
        .arst_n            (arst_n),
        .red_average       (red_average),
        .green_average     (green_average),
        .blue_average      (blue_average),
        .stats_valid       (stats_valid),
        .brightness_target (brightness_target),
        .deadband          (deadband),
        .exposure_step     (exposure_step),
        .exposure_value    (exposure_value),
        .exposure_update   (exposure_update)
    );

endmodule

`default_nettype wire

// File: source/exposure_stepper.sv
/*
 * Luma estimate from channel averages and a clamped up/down exposure step.
 */
`timescale 1ns/1ps
`default_nettype none

module exposure_stepper #(
    parameter int unsigned EXPOSURE_MIN     = 16,
    parameter int unsigned EXPOSURE_MAX     = 4000,
    parameter int unsigned EXPOSURE_INITIAL = 1000
) (
    input  wire                                           pixel_clock_in,
    input  wire                                           arst_n,

    // Frame statistics.
    input  wire  [camera_metering_pkg::AVERAGE_WIDTH-1:0]  red_average,
    input  wire  [camera_metering_pkg::AVERAGE_WIDTH-1:0]  green_average,
    input  wire  [camera_metering_pkg::AVERAGE_WIDTH-1:0]  blue_average,
    input  wire                                           stats_valid,

    // Loop settings.
    input  wire  [camera_metering_pkg::AVERAGE_WIDTH-1:0]  brightness_target,
    input  wire  [camera_metering_pkg::AVERAGE_WIDTH-1:0]  deadband,
    input  wire  [camera_metering_pkg::EXPOSURE_WIDTH-1:0] exposure_step,

    output logic [camera_metering_pkg::EXPOSURE_WIDTH-1:0] exposure_value,
    output logic                                          exposure_update
);

    import camera_metering_pkg::*;

    localparam logic [EXPOSURE_WIDTH:0]   MIN_LIMIT     = (EXPOSURE_WIDTH + 1)'(EXPOSURE_MIN);
    localparam logic [EXPOSURE_WIDTH:0]   MAX_LIMIT     = (EXPOSURE_WIDTH + 1)'(EXPOSURE_MAX);
    localparam logic [EXPOSURE_WIDTH-1:0] INITIAL_VALUE = EXPOSURE_WIDTH'(EXPOSURE_INITIAL);

    logic [AVERAGE_WIDTH+1:0]  luma_total;
    logic [AVERAGE_WIDTH-1:0]  luma;
    logic [AVERAGE_WIDTH:0]    luma_plus_deadband;
    logic [AVERAGE_WIDTH:0]    target_plus_deadband;
    logic                      too_dark;
    logic                      too_bright;

    logic [EXPOSURE_WIDTH:0]   raised_exposure;
    logic [EXPOSURE_WIDTH:0]   lower_limit;
    logic [EXPOSURE_WIDTH-1:0] next_exposure;

    // Luma as (R + 2G + B) / 4 with truncation.
    assign luma_total = {2'b00, red_average}
                      + {1'b0, green_average, 1'b0}
                      + {2'b00, blue_average};
    assign luma       = luma_total[AVERAGE_WIDTH+1:2];

    // Band compare, widened by one bit so the sums never wrap.
    assign luma_plus_deadband   = {1'b0, luma} + {1'b0, deadband};
    assign target_plus_deadband = {1'b0, brightness_target} + {1'b0, deadband};
    assign too_dark   = luma_plus_deadband < {1'b0, brightness_target};
    assign too_bright = {1'b0, luma} > target_plus_deadband;

    assign raised_exposure = {1'b0, exposure_value} + {1'b0, exposure_step};
    // Below this value a full step would cross the floor.
    assign lower_limit     = {1'b0, exposure_step} + MIN_LIMIT;

    always_comb begin
        next_exposure = exposure_value;
        if (too_dark) begin
            if (raised_exposure > MAX_LIMIT) begin
                next_exposure = MAX_LIMIT[EXPOSURE_WIDTH-1:0];
            end else begin
                next_exposure = raised_exposure[EXPOSURE_WIDTH-1:0];
            end
        end else if (too_bright) begin
            if ({1'b0, exposure_value} < lower_limit) begin
                next_exposure = MIN_LIMIT[EXPOSURE_WIDTH-1:0];
            end else begin
                next_exposure = exposure_value - exposure_step;
            end
        end
    end

    // The update pulse follows every statistics pulse, even when the value holds.
    always_ff @(posedge pixel_clock_in or negedge arst_n) begin
        if (!arst_n) begin
            exposure_value  <= INITIAL_VALUE;
            exposure_update <= 1'b0;
        end else begin
            exposure_update <= stats_valid;
            if (stats_valid) begin
                exposure_value <= next_exposure;
            end
        end
    end

endmodule

`default_nettype wire

// File: source/metering_config_regs.sv
/*
 * Metering configuration registers with write decode and readback mux.
 */
`timescale 1ns/1ps
`default_nettype none

module metering_config_regs (
    input  wire                                              pixel_clock_in,
    input  wire                                              arst_n,

    // Register port.
    input  wire                                              cfg_write,
    input  wire  [camera_metering_pkg::CFG_ADDRESS_WIDTH-1:0] cfg_address,
    input  wire  [camera_metering_pkg::CFG_DATA_WIDTH-1:0]    cfg_write_data,
    output logic [camera_metering_pkg::CFG_DATA_WIDTH-1:0]    cfg_read_data,

    // Window origin for the statistics block.
    output logic [camera_metering_pkg::COORD_WIDTH-1:0]       x_window_start,
    output logic [camera_metering_pkg::COORD_WIDTH-1:0]       y_window_start,

    // Control loop settings for the exposure stepper.
    output logic [camera_metering_pkg::AVERAGE_WIDTH-1:0]     brightness_target,
    output logic [camera_metering_pkg::AVERAGE_WIDTH-1:0]     deadband,
    output logic [camera_metering_pkg::EXPOSURE_WIDTH-1:0]    exposure_step
);

    import camera_metering_pkg::*;

    logic write_x_window_start;
    logic write_y_window_start;
    logic write_brightness_target;
    logic write_deadband;
    logic write_exposure_step;

    // Address decode for the write strobes.
    assign write_x_window_start    = cfg_write && (cfg_address == REG_X_WINDOW_START);
    assign write_y_window_start    = cfg_write && (cfg_address == REG_Y_WINDOW_START);
    assign write_brightness_target = cfg_write && (cfg_address == REG_BRIGHTNESS_TARGET);
    assign write_deadband          = cfg_write && (cfg_address == REG_DEADBAND);
    assign write_exposure_step     = cfg_write && (cfg_address == REG_EXPOSURE_STEP);

    // Each register keeps the low bits of the written word.
    always_ff @(posedge pixel_clock_in or negedge arst_n) begin
        if (!arst_n) begin
            x_window_start    <= RESET_X_WINDOW_START;
            y_window_start    <= RESET_Y_WINDOW_START;
            brightness_target <= RESET_BRIGHTNESS_TARGET;
            deadband          <= RESET_DEADBAND;
            exposure_step     <= RESET_EXPOSURE_STEP;
        end else begin
            if (write_x_window_start) begin
                x_window_start <= cfg_write_data[COORD_WIDTH-1:0];
            end
            if (write_y_window_start) begin
                y_window_start <= cfg_write_data[COORD_WIDTH-1:0];
            end
            if (write_brightness_target) begin
                brightness_target <= cfg_write_data[AVERAGE_WIDTH-1:0];
            end
            if (write_deadband) begin
                deadband <= cfg_write_data[AVERAGE_WIDTH-1:0];
            end
            if (write_exposure_step) begin
                exposure_step <= cfg_write_data[EXPOSURE_WIDTH-1:0];
            end
        end
    end

    // Readback is zero-extended, unmapped addresses return zero.
    always_comb begin
        case (cfg_address)
            REG_X_WINDOW_START: begin
                cfg_read_data = CFG_DATA_WIDTH'(x_window_start);
            end
            REG_Y_WINDOW_START: begin
                cfg_read_data = CFG_DATA_WIDTH'(y_window_start);
            end
            REG_BRIGHTNESS_TARGET: begin
                cfg_read_data = CFG_DATA_WIDTH'(brightness_target);
            end
            REG_DEADBAND: begin
                cfg_read_data = CFG_DATA_WIDTH'(deadband);
            end
            REG_EXPOSURE_STEP: begin
                cfg_read_data = CFG_DATA_WIDTH'(exposure_step);
            end
            default: begin
                cfg_read_data = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: source/window_brightness.sv
/*
 * Windowed RGB statistics: pixel and line counters, per-channel sums over a
 * square window and channel averages published at frame end.
 */
`timescale 1ns/1ps
`default_nettype none

module window_brightness #(
    parameter int unsigned WINDOW_SIZE_LOG2 = 4
) (
    input  wire                                          pixel_clock_in,
    input  wire                                          arst_n,

    // Raw pixel stream.
    input  wire  [camera_metering_pkg::PIXEL_WIDTH-1:0]   pixel_red,
    input  wire  [camera_metering_pkg::PIXEL_WIDTH-1:0]   pixel_green,
    input  wire  [camera_metering_pkg::PIXEL_WIDTH-1:0]   pixel_blue,
    input  wire                                          line_valid,
    input  wire                                          frame_valid,

    // Window origin.
    input  wire  [camera_metering_pkg::COORD_WIDTH-1:0]   x_window_start,
    input  wire  [camera_metering_pkg::COORD_WIDTH-1:0]   y_window_start,

    // Published statistics.
    output logic [camera_metering_pkg::AVERAGE_WIDTH-1:0] red_average,
    output logic [camera_metering_pkg::AVERAGE_WIDTH-1:0] green_average,
    output logic [camera_metering_pkg::AVERAGE_WIDTH-1:0] blue_average,
    output logic                                         stats_valid
);

    import camera_metering_pkg::*;

    localparam int unsigned WINDOW_SIZE   = 1 << WINDOW_SIZE_LOG2;
    // Wide enough for a full window of full-scale samples.
    localparam int unsigned SUM_WIDTH     = PIXEL_WIDTH + 2 * WINDOW_SIZE_LOG2;
    // Divide by the window area and by 4 to go from 10 to 8 bits.
    localparam int unsigned AVERAGE_SHIFT = 2 * WINDOW_SIZE_LOG2 + 2;

    logic [COORD_WIDTH-1:0] x_count;
    logic [COORD_WIDTH-1:0] y_count;
    logic                   previous_line_valid;
    logic                   previous_frame_valid;
    logic                   pixel_valid;
    logic                   frame_end;

    logic [COORD_WIDTH:0]   x_window_end;
    logic [COORD_WIDTH:0]   y_window_end;
    logic                   inside_window;

    logic [SUM_WIDTH-1:0]   red_sum;
    logic [SUM_WIDTH-1:0]   green_sum;
    logic [SUM_WIDTH-1:0]   blue_sum;

    assign pixel_valid = line_valid && frame_valid;
    assign frame_end   = previous_frame_valid && !frame_valid;

    // One extra bit so a window near the counter limit does not wrap.
    assign x_window_end = {1'b0, x_window_start} + (COORD_WIDTH + 1)'(WINDOW_SIZE);
    assign y_window_end = {1'b0, y_window_start} + (COORD_WIDTH + 1)'(WINDOW_SIZE);

    assign inside_window = pixel_valid
                        && (x_count >= x_window_start)
                        && ({1'b0, x_count} < x_window_end)
                        && (y_count >= y_window_start)
                        && ({1'b0, y_count} < y_window_end);

    // Position counters, x follows the pixels, y follows line ends.
    always_ff @(posedge pixel_clock_in or negedge arst_n) begin
        if (!arst_n) begin
            x_count             <= '0;
            y_count             <= '0;
            previous_line_valid <= 1'b0;
        end else if (!frame_valid) begin
            x_count             <= '0;
            y_count             <= '0;
            previous_line_valid <= 1'b0;
        end else begin
            previous_line_valid <= line_valid;
            if (line_valid) begin
                x_count <= x_count + 1'b1;
            end else begin
                x_count <= '0;
                if (previous_line_valid) begin
                    y_count <= y_count + 1'b1;
                end
            end
        end
    end

    // Channel sums restart with every frame.
    always_ff @(posedge pixel_clock_in or negedge arst_n) begin
        if (!arst_n) begin
            red_sum   <= '0;
            green_sum <= '0;
            blue_sum  <= '0;
        end else if (!frame_valid) begin
            red_sum   <= '0;
            green_sum <= '0;
            blue_sum  <= '0;
        end else if (inside_window) begin
            red_sum   <= red_sum + pixel_red;
            green_sum <= green_sum + pixel_green;
            blue_sum  <= blue_sum + pixel_blue;
        end
    end

    // The sums still hold the finished frame on the edge that sees frame_valid drop.
    always_ff @(posedge pixel_clock_in or negedge arst_n) begin
        if (!arst_n) begin
            previous_frame_valid <= 1'b0;
            stats_valid          <= 1'b0;
            red_average          <= '0;
            green_average        <= '0;
            blue_average         <= '0;
        end else begin
            previous_frame_valid <= frame_valid;
            stats_valid          <= frame_end;
            if (frame_end) begin
                red_average   <= red_sum[AVERAGE_SHIFT +: AVERAGE_WIDTH];
                green_average <= green_sum[AVERAGE_SHIFT +: AVERAGE_WIDTH];
                blue_average  <= blue_sum[AVERAGE_SHIFT +: AVERAGE_WIDTH];
            end
        end
    end

endmodule

`default_nettype wire

// File: verif/camera_metering_tb.sv
/*
 * Metering testbench: clock and reset, frame generator, reference model,
 * assertions and per-test reporting.
 */
`timescale 1ns/1ps
`default_nettype none

module camera_metering_tb;

    import camera_metering_pkg::*;

    localparam int WINDOW_SIZE_LOG2 = 4;
    localparam int EXPOSURE_MIN     = 16;
    localparam int EXPOSURE_MAX     = 4000;
    localparam int EXPOSURE_INITIAL = 1000;
    localparam int WINDOW_SIZE      = 1 << WINDOW_SIZE_LOG2;
    // Window area times 4 takes a 10-bit mean down to 8 bits.
    localparam int AVERAGE_DIVISOR  = WINDOW_SIZE * WINDOW_SIZE * 4;
    localparam int FRAME_PIXELS     = 120;
    localparam int FRAME_LINES      = 110;
    localparam int LINE_BLANKING    = 6;
    localparam int FRAME_BLANKING   = 10;
    localparam int RESULT_TIMEOUT   = 20;
    localparam int PATTERN_UNIFORM  = 0;
    localparam int PATTERN_RANDOM   = 1;
    localparam int PATTERN_SQUARE   = 2;

    logic                         pixel_clock_in;
    logic                         arst_n;
    logic [PIXEL_WIDTH-1:0]       pixel_red;
    logic [PIXEL_WIDTH-1:0]       pixel_green;
    logic [PIXEL_WIDTH-1:0]       pixel_blue;
    logic                         line_valid;
    logic                         frame_valid;
    logic                         cfg_write;
    logic [CFG_ADDRESS_WIDTH-1:0] cfg_address;
    logic [CFG_DATA_WIDTH-1:0]    cfg_write_data;
    logic [CFG_DATA_WIDTH-1:0]    cfg_read_data;
    logic [AVERAGE_WIDTH-1:0]     red_average;
    logic [AVERAGE_WIDTH-1:0]     green_average;
    logic [AVERAGE_WIDTH-1:0]     blue_average;
    logic                         stats_valid;
    logic [EXPOSURE_WIDTH-1:0]    exposure_value;
    logic                         exposure_update;

    int          error_count;
    int          property_error_count;
    int          test_error_mark;
    int          tests_passed;
    int          tests_failed;
    int          stats_pulse_count;
    int          frames_sent;
    string       abort_reason;
    event        abort_requested;
    logic [31:0] lcg_state;
    // Model copies of the registers, the window sums and the exposure loop.
    int          model_x_start;
    int          model_y_start;
    int          model_target;
    int          model_deadband;
    int          model_step;
    int          model_red_sum;
    int          model_green_sum;
    int          model_blue_sum;
    int          model_exposure;
    int          held_averages;

    camera_metering_top #(
        .WINDOW_SIZE_LOG2 (WINDOW_SIZE_LOG2),
        .EXPOSURE_MIN     (EXPOSURE_MIN),
        .EXPOSURE_MAX     (EXPOSURE_MAX),
        .EXPOSURE_INITIAL (EXPOSURE_INITIAL)
    ) UUT (.*);

    initial begin
        pixel_clock_in = 1'b0;
        forever #20 pixel_clock_in = ~pixel_clock_in;
    end

    always @(negedge pixel_clock_in) begin
        if (stats_valid) begin
            stats_pulse_count++;
        end
    end

    // Statistics pulse lasts one cycle and the exposure update comes right after it.
    assert property (@(posedge pixel_clock_in) disable iff (!arst_n)
                     stats_valid |=> (exposure_update && !stats_valid))
    else begin
        property_error_count++;
        $display("[ERROR] %0t: stats_valid not followed by one exposure_update", $time);
    end

    assert property (@(posedge pixel_clock_in) disable iff (!arst_n)
                     exposure_update |-> $past(stats_valid))
    else begin
        property_error_count++;
        $display("[ERROR] %0t: exposure_update without a preceding stats_valid", $time);
    end

    function automatic int total_errors();
        return error_count + property_error_count;
    endfunction

    // LCG step that returns ten bits from the upper half of the state.
    function automatic int random_sample();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return int'(lcg_state[25:16]);
    endfunction

    function automatic int next_model_exposure(input int luma);
        int result;
        result = model_exposure;
        if (luma + model_deadband < model_target) begin
            result = (model_exposure + model_step > EXPOSURE_MAX) ? EXPOSURE_MAX
                                                                 : model_exposure + model_step;
        end else if (luma > model_target + model_deadband) begin
            result = (model_exposure - model_step < EXPOSURE_MIN) ? EXPOSURE_MIN
                                                                 : model_exposure - model_step;
        end
        return result;
    endfunction

    task automatic step_cycle();
        @(posedge pixel_clock_in);
        #2;
    endtask

    task automatic check_value(input string what, input int actual, input int expected);
        assert (actual == expected) else begin
            error_count++;
            $display("[ERROR] %0t: %s is 0x%0h, expected 0x%0h", $time, what, actual, expected);
        end
    endtask

    task automatic finish_test(input string name);
        if (total_errors() == test_error_mark) begin
            tests_passed++;
            $display("Test %s: passed", name);
        end else begin
            tests_failed++;
            $display("Test %s: failed", name);
        end
        test_error_mark = total_errors();
    endtask

    task automatic write_register(input logic [CFG_ADDRESS_WIDTH-1:0] address, input int data);
        cfg_write      = 1'b1;
        cfg_address    = address;
        cfg_write_data = CFG_DATA_WIDTH'(data);
        step_cycle();
        cfg_write = 1'b0;
        case (address)
            REG_X_WINDOW_START:    model_x_start  = data & ((1 << COORD_WIDTH) - 1);
            REG_Y_WINDOW_START:    model_y_start  = data & ((1 << COORD_WIDTH) - 1);
            REG_BRIGHTNESS_TARGET: model_target   = data & ((1 << AVERAGE_WIDTH) - 1);
            REG_DEADBAND:          model_deadband = data & ((1 << AVERAGE_WIDTH) - 1);
            REG_EXPOSURE_STEP:     model_step     = data & ((1 << EXPOSURE_WIDTH) - 1);
            default:               ;
        endcase
    endtask

    task automatic expect_readback(input logic [CFG_ADDRESS_WIDTH-1:0] address,
                                   input int expected);
        cfg_address = address;
        #10;
        check_value($sformatf("register %0d", address), int'(cfg_read_data), expected);
        step_cycle();
    endtask

    task automatic expect_registers(input int x_start, input int y_start, input int target,
                                    input int band, input int step);
        expect_readback(REG_X_WINDOW_START, x_start);
        expect_readback(REG_Y_WINDOW_START, y_start);
        expect_readback(REG_BRIGHTNESS_TARGET, target);
        expect_readback(REG_DEADBAND, band);
        expect_readback(REG_EXPOSURE_STEP, step);
    endtask

    // One frame of 120 by 110 pixels; the model sums what falls in its window.
    task automatic drive_frame(input int pattern, input int level, input int square_x,
                               input int square_y);
        int red;
        int green;
        int blue;
        model_red_sum   = 0;
        model_green_sum = 0;
        model_blue_sum  = 0;
        frame_valid     = 1'b1;
        for (int y = 0; y < FRAME_LINES; y++) begin
            line_valid = 1'b0;
            check_value("held averages", int'({red_average, green_average, blue_average}),
                        held_averages);
            repeat (LINE_BLANKING) step_cycle();
            for (int x = 0; x < FRAME_PIXELS; x++) begin
                red = level;
                if (pattern == PATTERN_SQUARE && !(x >= square_x && x < square_x + WINDOW_SIZE
                        && y >= square_y && y < square_y + WINDOW_SIZE)) begin
                    red = 0;
                end
                green = red;
                blue  = red;
                if (pattern == PATTERN_RANDOM) begin
                    red   = random_sample();
                    green = random_sample();
                    blue  = random_sample();
                end
                pixel_red   = PIXEL_WIDTH'(red);
                pixel_green = PIXEL_WIDTH'(green);
                pixel_blue  = PIXEL_WIDTH'(blue);
                line_valid  = 1'b1;
                if (x >= model_x_start && x < model_x_start + WINDOW_SIZE
                        && y >= model_y_start && y < model_y_start + WINDOW_SIZE) begin
                    model_red_sum   += red;
                    model_green_sum += green;
                    model_blue_sum  += blue;
                end
                step_cycle();
            end
        end
        line_valid  = 1'b0;
        frame_valid = 1'b0;
    endtask

    task automatic collect_frame_results();
        int red;
        int green;
        int blue;
        int waited;
        red    = model_red_sum / AVERAGE_DIVISOR;
        green  = model_green_sum / AVERAGE_DIVISOR;
        blue   = model_blue_sum / AVERAGE_DIVISOR;
        waited = 0;
        while (stats_valid !== 1'b1 && waited < RESULT_TIMEOUT) begin
            step_cycle();
            waited++;
        end
        if (stats_valid !== 1'b1) begin
            abort_reason = "Timeout: stats_valid did not pulse after the frame ended.";
            -> abort_requested;
            @(posedge pixel_clock_in);
        end
        held_averages = (red << 16) | (green << 8) | blue;
        check_value("averages", int'({red_average, green_average, blue_average}), held_averages);
        model_exposure = next_model_exposure((red + 2 * green + blue) / 4);
        waited = 0;
        while (exposure_update !== 1'b1 && waited < RESULT_TIMEOUT) begin
            step_cycle();
            waited++;
        end
        if (exposure_update !== 1'b1) begin
            abort_reason = "Timeout: exposure_update did not pulse after stats_valid.";
            -> abort_requested;
            @(posedge pixel_clock_in);
        end
        check_value("exposure_value", int'(exposure_value), model_exposure);
        frames_sent++;
        repeat (FRAME_BLANKING - 2) step_cycle();
        check_value("stats_valid pulse count", stats_pulse_count, frames_sent);
    endtask

    initial begin
        @(abort_requested);
        $display("%s", abort_reason);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        int guard;
        int exposure_before;
        arst_n         = 1'b0;
        pixel_red      = '0;
        pixel_green    = '0;
        pixel_blue     = '0;
        line_valid     = 1'b0;
        frame_valid    = 1'b0;
        cfg_write      = 1'b0;
        cfg_address    = '0;
        cfg_write_data = '0;
        lcg_state      = 32'h6f8e;
        model_x_start  = int'(RESET_X_WINDOW_START);
        model_y_start  = int'(RESET_Y_WINDOW_START);
        model_target   = int'(RESET_BRIGHTNESS_TARGET);
        model_deadband = int'(RESET_DEADBAND);
        model_step     = int'(RESET_EXPOSURE_STEP);
        model_exposure = EXPOSURE_INITIAL;
        repeat (3) @(posedge pixel_clock_in);
        #2;
        arst_n = 1'b1;

        check_value("averages after reset", int'({red_average, green_average, blue_average}), 0);
        check_value("result pulses after reset", int'({stats_valid, exposure_update}), 0);
        check_value("exposure_value after reset", int'(exposure_value), EXPOSURE_INITIAL);
        expect_registers(model_x_start, model_y_start, model_target, model_deadband, model_step);
        finish_test("reset state");

        write_register(REG_X_WINDOW_START, 'hABCD);
        write_register(REG_Y_WINDOW_START, 'h1234);
        write_register(REG_BRIGHTNESS_TARGET, 'h5A7F);
        write_register(REG_DEADBAND, 'hFF11);
        write_register(REG_EXPOSURE_STEP, 'hBEEF);
        expect_registers('hBCD, 'h234, 'h7F, 'h11, 'hBEEF);
        write_register(4'd9, 'hFFFF);
        expect_readback(4'd9, 0);
        expect_registers('hBCD, 'h234, 'h7F, 'h11, 'hBEEF);
        write_register(REG_X_WINDOW_START, int'(RESET_X_WINDOW_START));
        write_register(REG_Y_WINDOW_START, int'(RESET_Y_WINDOW_START));
        write_register(REG_BRIGHTNESS_TARGET, int'(RESET_BRIGHTNESS_TARGET));
        write_register(REG_DEADBAND, int'(RESET_DEADBAND));
        write_register(REG_EXPOSURE_STEP, int'(RESET_EXPOSURE_STEP));
        finish_test("register access");

        drive_frame(PATTERN_UNIFORM, 600, 0, 0);
        collect_frame_results();
        check_value("uniform averages", int'({red_average, green_average, blue_average}),
                    (150 << 16) | (150 << 8) | 150);
        drive_frame(PATTERN_RANDOM, 0, 0, 0);
        collect_frame_results();
        finish_test("windowed averages");

        write_register(REG_X_WINDOW_START, 30);
        write_register(REG_Y_WINDOW_START, 40);
        drive_frame(PATTERN_SQUARE, 1023, 30, 40);
        collect_frame_results();
        check_value("square at new origin", int'(green_average), 255);
        drive_frame(PATTERN_SQUARE, 1023, 82, 82);
        collect_frame_results();
        check_value("square at old origin near zero", int'(green_average <= 8'd2), 1);
        finish_test("window origin");

        write_register(REG_EXPOSURE_STEP, 700);
        for (guard = 0; guard < 10 && model_exposure < EXPOSURE_MAX; guard++) begin
            drive_frame(PATTERN_UNIFORM, 0, 0, 0);
            collect_frame_results();
        end
        drive_frame(PATTERN_UNIFORM, 0, 0, 0);
        collect_frame_results();
        check_value("exposure after dark frames", int'(exposure_value), EXPOSURE_MAX);
        write_register(REG_EXPOSURE_STEP, 1500);
        for (guard = 0; guard < 10 && model_exposure > EXPOSURE_MIN; guard++) begin
            drive_frame(PATTERN_UNIFORM, 1023, 0, 0);
            collect_frame_results();
        end
        drive_frame(PATTERN_UNIFORM, 1023, 0, 0);
        collect_frame_results();
        check_value("exposure after bright frames", int'(exposure_value), EXPOSURE_MIN);
        // A dark frame lifts the value off the floor before the deadband frames.
        write_register(REG_EXPOSURE_STEP, int'(RESET_EXPOSURE_STEP));
        drive_frame(PATTERN_UNIFORM, 0, 0, 0);
        collect_frame_results();
        // Luma 120 and 136 sit on the two edges of the deadband.
        exposure_before = model_exposure;
        drive_frame(PATTERN_UNIFORM, 480, 0, 0);
        collect_frame_results();
        drive_frame(PATTERN_UNIFORM, 544, 0, 0);
        collect_frame_results();
        check_value("exposure inside deadband", int'(exposure_value), exposure_before);
        finish_test("exposure control");

        $display("Tests passed: %0d, failed: %0d, errors: %0d", tests_passed, tests_failed,
                 total_errors());
        if (total_errors() == 0) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            abort_reason = "One or more checks failed.";
            -> abort_requested;
        end
    end

endmodule

`default_nettype wire
